// File: verilog/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OpRType = 6'b000000,
        OpJ     = 6'b000010,
        OpJal   = 6'b000011,
        OpBeq   = 6'b000100,
        OpOri   = 6'b001101,
        OpLui   = 6'b001111,
        OpLw    = 6'b100011,
        OpSw    = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FnSll  = 6'b000000,  // All-zero word is nop
        FnJr   = 6'b001000,
        FnJalr = 6'b001001,
        FnAddu = 6'b100000,
        FnSubu = 6'b100010
    } funct_e;

    ////////////////////////////////////////////////////////////
    // Datapath select codes
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        AluPass = 3'b000,  // B straight through
        AluOr   = 3'b001,
        AluAdd  = 3'b010,
        AluSub  = 3'b011,
        AluSll  = 3'b100
    } aluOp_e;

    typedef enum logic [1:0] {
        ExtSign  = 2'b00,
        ExtZero  = 2'b01,
        ExtUpper = 2'b10   // Immediate into bits 31..16
    } extOp_e;

    typedef enum logic [1:0] {
        WbAlu  = 2'b00,
        WbMem  = 2'b01,
        WbLink = 2'b10
    } wbSel_e;

    typedef enum logic [1:0] {
        DstRt = 2'b00,
        DstRd = 2'b01,
        DstRa = 2'b10
    } dstSel_e;

    typedef enum logic [1:0] {
        PcSeq    = 2'b00,
        PcReg    = 2'b01,
        PcBranch = 2'b10,
        PcJump   = 2'b11
    } pcSel_e;

    // Overlays the raw instruction word
    typedef struct packed {
        opcode_e    opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [4:0] shamt;
        funct_e     funct;
    } instrFields_t;

    typedef struct packed {
        aluOp_e  aluOp;
        extOp_e  extOp;
        logic    aSrcShamt;  // A operand from shamt field
        logic    bSrcImm;    // B operand from extended immediate
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        wbSel_e  wbSel;
        dstSel_e dstSel;
        pcSel_e  pcSel;
    } ctrl_t;

    // Nothing written, pc steps by 4
    localparam ctrl_t CtrlNop = '{
        aluOp:     AluPass,
        extOp:     ExtSign,
        aSrcShamt: 1'b0,
        bSrcImm:   1'b0,
        regWrite:  1'b0,
        memRead:   1'b0,
        memWrite:  1'b0,
        wbSel:     WbAlu,
        dstSel:    DstRt,
        pcSel:     PcSeq
    };

    localparam regIdx_t RegLink = 5'd31;

    function automatic logic [15:0] immOf(instrFields_t f);
        return {f.rd, f.shamt, f.funct};
    endfunction

    function automatic logic [25:0] targetOf(instrFields_t f);
        return {f.rs, f.rt, f.rd, f.shamt, f.funct};
    endfunction

endpackage

// File: verilog/instrDecoder.sv
module instrDecoder
    import mipsPkg::*;
(
    input  logic         rstN,
    input  instrFields_t fields,
    output ctrl_t        ctrl
);

    ctrl_t decoded;

    ////////////////////////////////////////////////////////////
    // Opcode and function decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        decoded = CtrlNop;  // Undefined encodings stay nop
        case (fields.opcode)
            OpRType:
            begin
                case (fields.funct)
                    FnAddu:
                    begin
                        decoded.aluOp    = AluAdd;
                        decoded.dstSel   = DstRd;
                        decoded.regWrite = 1'b1;
                    end
                    FnSubu:
                    begin
                        decoded.aluOp    = AluSub;
                        decoded.dstSel   = DstRd;
                        decoded.regWrite = 1'b1;
                    end
                    FnSll:
                    begin
                        decoded.aluOp     = AluSll;
                        decoded.aSrcShamt = 1'b1;
                        decoded.dstSel    = DstRd;
                        decoded.regWrite  = 1'b1;  // Lands on $0 for nop
                    end
                    FnJr:
                    begin
                        decoded.pcSel = PcReg;  // No link write
                    end
                    FnJalr:
                    begin
                        decoded.pcSel    = PcReg;
                        decoded.wbSel    = WbLink;
                        decoded.dstSel   = DstRd;
                        decoded.regWrite = 1'b1;
                    end
                    default:
                    begin
                        decoded = CtrlNop;
                    end
                endcase
            end
            OpLw:
            begin
                decoded.aluOp    = AluAdd;
                decoded.bSrcImm  = 1'b1;
                decoded.wbSel    = WbMem;
                decoded.regWrite = 1'b1;
                decoded.memRead  = 1'b1;
            end
            OpSw:
            begin
                decoded.aluOp    = AluAdd;
                decoded.bSrcImm  = 1'b1;
                decoded.memWrite = 1'b1;
            end
            OpBeq:
            begin
                decoded.aluOp = AluSub;  // Zero flag decides
                decoded.pcSel = PcBranch;
            end
            OpLui:
            begin
                decoded.aluOp    = AluPass;
                decoded.extOp    = ExtUpper;
                decoded.bSrcImm  = 1'b1;
                decoded.regWrite = 1'b1;
            end
            OpOri:
            begin
                decoded.aluOp    = AluOr;
                decoded.extOp    = ExtZero;
                decoded.bSrcImm  = 1'b1;
                decoded.regWrite = 1'b1;
            end
            OpJal:
            begin
                decoded.pcSel    = PcJump;
                decoded.wbSel    = WbLink;
                decoded.dstSel   = DstRa;
                decoded.regWrite = 1'b1;
            end
            OpJ:
            begin
                decoded.pcSel = PcJump;
            end
            default:
            begin
                decoded = CtrlNop;
            end
        endcase
    end

    // No writes or reads go out while in reset
    always_comb
    begin
        ctrl          = decoded;
        ctrl.regWrite = decoded.regWrite & rstN;
        ctrl.memRead  = decoded.memRead & rstN;
        ctrl.memWrite = decoded.memWrite & rstN;
    end

endmodule

// File: verilog/regFile.sv
module regFile
    import mipsPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regIdx_t raddrA,
    input  regIdx_t raddrB,
    output word_t   rdataA,
    output word_t   rdataB,
    input  logic    we,
    input  regIdx_t waddr,
    input  word_t   wdata
);

    word_t regs [1:31];  // $0 has no storage

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    // Old value seen until the edge
    always_comb
    begin
        rdataA = '0;
        rdataB = '0;
        if (raddrA != '0)
        begin
            rdataA = regs[raddrA];
        end
        if (raddrB != '0)
        begin
            rdataB = regs[raddrB];
        end
    end

endmodule

// File: verilog/executeUnit.sv
module executeUnit
    import mipsPkg::*;
(
    input  instrFields_t fields,
    input  ctrl_t        ctrl,
    input  word_t        rsVal,
    input  word_t        rtVal,
    output word_t        aluResult,
    output logic         zero
);

    logic [15:0] imm;
    word_t       immExt;
    word_t       opA;
    word_t       opB;
    word_t       diff;

    ////////////////////////////////////////////////////////////
    // Operands
    ////////////////////////////////////////////////////////////

    assign imm = immOf(fields);

    always_comb
    begin
        case (ctrl.extOp)
            ExtZero:
            begin
                immExt = {16'h0000, imm};
            end
            ExtUpper:
            begin
                immExt = {imm, 16'h0000};  // lui
            end
            default:
            begin
                immExt = {{16{imm[15]}}, imm};
            end
        endcase
    end

    assign opA = ctrl.aSrcShamt ? {27'd0, fields.shamt} : rsVal;
    assign opB = ctrl.bSrcImm ? immExt : rtVal;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    assign diff = opA - opB;  // Wraps, no overflow trap

    always_comb
    begin
        case (ctrl.aluOp)
            AluOr:   aluResult = opA | opB;
            AluAdd:  aluResult = opA + opB;
            AluSub:  aluResult = diff;
            AluSll:  aluResult = opB << opA[4:0];
            default: aluResult = opB;  // AluPass
        endcase
    end

    // Equality for beq
    assign zero = (diff == '0);

endmodule

// File: verilog/resultStage.sv
module resultStage
    import mipsPkg::*;
#(
    parameter word_t ResetPc = 32'h0000_0000
)
(
    input  logic         clk,
    input  logic         rstN,
    input  instrFields_t fields,
    input  ctrl_t        ctrl,
    input  word_t        rsVal,
    input  word_t        aluResult,
    input  logic         zero,
    input  word_t        memRdata,
    output regIdx_t      waddr,
    output word_t        wdata,
    output word_t        pc
);

    logic [15:0] imm;
    word_t       pcPlus4;
    word_t       branchTarget;
    word_t       jumpTarget;
    word_t       nextPc;

    ////////////////////////////////////////////////////////////
    // Write-back select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.dstSel)
            DstRd:   waddr = fields.rd;
            DstRa:   waddr = RegLink;  // jal
            default: waddr = fields.rt;
        endcase
    end

    always_comb
    begin
        case (ctrl.wbSel)
            WbMem:   wdata = memRdata;
            WbLink:  wdata = pcPlus4;
            default: wdata = aluResult;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////////////////////////

    assign imm          = immOf(fields);
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], targetOf(fields), 2'b00};

    always_comb
    begin
        case (ctrl.pcSel)
            PcReg:    nextPc = rsVal;  // jr, jalr
            PcBranch: nextPc = zero ? branchTarget : pcPlus4;
            PcJump:   nextPc = jumpTarget;
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc <= ResetPc;
        end
        else
        begin
            pc <= nextPc;
        end
    end

endmodule

// File: verilog/mipsCore.sv
module mipsCore
    import mipsPkg::*;
#(
    parameter word_t ResetPc = 32'h0000_0000
)
(
    input  logic  clk,
    input  logic  rstN,
    // Fetch side
    output word_t pc,
    input  word_t instr,
    // Data side
    output word_t memAddr,
    output word_t memWdata,
    output logic  memWe,
    output logic  memRe,
    input  word_t memRdata
);

    instrFields_t fields;
    ctrl_t        ctrl;
    word_t        rsVal;
    word_t        rtVal;
    word_t        aluResult;
    logic         zero;
    regIdx_t      waddr;
    word_t        wdata;

    assign fields = instrFields_t'(instr);

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    instrDecoder decode0 (
        .rstN   (rstN),
        .fields (fields),
        .ctrl   (ctrl)
    );

    regFile regs0 (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (fields.rs),
        .raddrB (fields.rt),
        .rdataA (rsVal),
        .rdataB (rtVal),
        .we     (ctrl.regWrite),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    executeUnit exec0 (
        .fields    (fields),
        .ctrl      (ctrl),
        .rsVal     (rsVal),
        .rtVal     (rtVal),
        .aluResult (aluResult),
        .zero      (zero)
    );

    resultStage #(
        .ResetPc (ResetPc)
    ) result0 (
        .clk       (clk),
        .rstN      (rstN),
        .fields    (fields),
        .ctrl      (ctrl),
        .rsVal     (rsVal),
        .aluResult (aluResult),
        .zero      (zero),
        .memRdata  (memRdata),
        .waddr     (waddr),
        .wdata     (wdata),
        .pc        (pc)
    );

    // Data memory port
    assign memAddr  = aluResult;  // Base plus offset
    assign memWdata = rtVal;
    assign memWe    = ctrl.memWrite;
    assign memRe    = ctrl.memRead;

endmodule

// File: verification/mipsCore_assert.sv
module mipsCoreAssert
    import mipsPkg::*;
(
    input logic  clk,
    input logic  rstN,
    input word_t pc,
    input logic  memWe,
    input logic  memRe
);

    ////////////////////////////////////////////////////////////
    // Data port enables
    ////////////////////////////////////////////////////////////

    // A single instruction never loads and stores at once
    loadStoreExclusive: assert property (@(posedge clk) !(memWe && memRe))
        else $error("memWe and memRe are high together");

    quietInReset: assert property (@(posedge clk) !rstN |-> (!memWe && !memRe))
        else $error("memory enable active while in reset");

    ////////////////////////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////////////////////////

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

bind mipsCore mipsCoreAssert assert0 (
    .clk   (clk),
    .rstN  (rstN),
    .pc    (pc),
    .memWe (memWe),
    .memRe (memRe)
);

// File: verification/mipsCoreTb.sv
module mipsCoreTb
    import mipsPkg::*;
();

    localparam word_t ResetPc  = 32'h0000_0000;
    localparam int    MaxSteps = 64;

    // One row of the program table
    typedef struct packed {
        word_t instr;
        word_t nextPc;
        logic  isStore;
        logic  isLoad;
        word_t addr;
        word_t data;
    } step_t;

    logic  clk;
    logic  rstN;
    word_t pc;
    word_t instr;
    word_t memAddr;
    word_t memWdata;
    word_t memRdata;
    logic  memWe;
    logic  memRe;

    word_t imem [0:127];
    word_t dmem [0:127];
    step_t prog [MaxSteps];
    string stepName [MaxSteps];
    int    numSteps;
    int    cycles;
    int    cycleLimit;
    int    seed;
    word_t randWord;
    word_t curPc;

    mipsCore #(
        .ResetPc (ResetPc)
    ) dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .pc       (pc),
        .instr    (instr),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .memRe    (memRe),
        .memRdata (memRdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    assign instr    = rstN ? imem[pc[8:2]] : 32'h0000_0000;  // nop in reset
    assign memRdata = dmem[memAddr[8:2]];

    always @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 128; i++)
            begin
                dmem[i[6:0]] <= 32'hD000_0000 | (i << 2);
            end
            dmem[7'h60] <= randWord;  // Word at 0x180
        end
        else if (memWe)
        begin
            dmem[memAddr[8:2]] <= memWdata;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycleLimit)
        begin
            $display("Error: simulation did not finish within %0d cycles", cycleLimit);
            abortRun();
        end
    end

    ////////////////////////////////////////////////////////////
    // Encoders, table and checks
    ////////////////////////////////////////////////////////////

    function automatic word_t rInstr(regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                     logic [4:0] sh, logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iInstr(logic [5:0] op, regIdx_t rs, regIdx_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jInstr(logic [5:0] op, logic [25:0] tgt);
        return {op, tgt};
    endfunction

    task automatic addStep(string name, word_t ins, word_t next);
        stepName[numSteps] = name;
        prog[numSteps]     = '{ins, next, 1'b0, 1'b0, 32'h0, 32'h0};
        numSteps++;
    endtask

    task automatic addStore(string name, word_t ins, word_t next, word_t a, word_t d);
        stepName[numSteps] = name;
        prog[numSteps]     = '{ins, next, 1'b1, 1'b0, a, d};
        numSteps++;
    endtask

    task automatic addLoad(string name, word_t ins, word_t next, word_t a);
        stepName[numSteps] = name;
        prog[numSteps]     = '{ins, next, 1'b0, 1'b1, a, 32'h0};
        numSteps++;
    endtask

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkWord(string name, word_t expected, word_t actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
            abortRun();
        end
    endtask

    // Execution trace, next pc and store values worked out by hand
    task automatic buildProgram();
        addStep("lui const", iInstr(OpLui, 5'd0, 5'd1, 16'h1234), 32'h04);
        addStep("ori const", iInstr(OpOri, 5'd1, 5'd1, 16'h5678), 32'h08);
        addStep("ori base", iInstr(OpOri, 5'd0, 5'd2, 16'h0100), 32'h0C);
        addStore("sw const", iInstr(OpSw, 5'd2, 5'd1, 16'h0000), 32'h10, 32'h100, 32'h12345678);
        addStep("ori five", iInstr(OpOri, 5'd0, 5'd3, 16'h0005), 32'h14);
        addStep("subu wrap", rInstr(5'd3, 5'd1, 5'd4, 5'd0, FnSubu), 32'h18);
        addStep("addu wrap", rInstr(5'd4, 5'd1, 5'd5, 5'd0, FnAddu), 32'h1C);
        addStore("sw subu", iInstr(OpSw, 5'd2, 5'd4, 16'h0004), 32'h20, 32'h104, 32'hEDCBA98D);
        addStore("sw addu", iInstr(OpSw, 5'd2, 5'd5, 16'h0008), 32'h24, 32'h108, 32'h00000005);
        addStep("sll", rInstr(5'd0, 5'd1, 5'd6, 5'd4, FnSll), 32'h28);
        addStore("sw sll", iInstr(OpSw, 5'd2, 5'd6, 16'h000C), 32'h2C, 32'h10C, 32'h23456780);
        addStep("ori ptr", iInstr(OpOri, 5'd0, 5'd7, 16'h0190), 32'h30);
        addLoad("lw random", iInstr(OpLw, 5'd7, 5'd8, 16'hFFF0), 32'h34, 32'h180);  // 0x190 - 16
        addStore("sw loaded", iInstr(OpSw, 5'd7, 5'd8, 16'hFFFC), 32'h38, 32'h18C, randWord);
        addStep("beq taken", iInstr(OpBeq, 5'd3, 5'd5, 16'h0002), 32'h44);
        addStep("beq not taken", iInstr(OpBeq, 5'd3, 5'd1, 16'h0005), 32'h48);
        addStep("j forward", jInstr(OpJ, 26'h000018), 32'h60);
        addStep("beq back", iInstr(OpBeq, 5'd0, 5'd0, 16'hFFFA), 32'h4C);  // 0x64 - 24
        addStep("jal", jInstr(OpJal, 26'h00001C), 32'h70);
        addStore("sw jal link", iInstr(OpSw, 5'd2, 5'd31, 16'h0010), 32'h74, 32'h110, 32'h50);
        addStep("jr", rInstr(5'd31, 5'd0, 5'd1, 5'd0, FnJr), 32'h50);  // rd field must not write
        addStep("ori jalr target", iInstr(OpOri, 5'd0, 5'd9, 16'h0080), 32'h54);
        addStep("jalr", rInstr(5'd9, 5'd0, 5'd10, 5'd0, FnJalr), 32'h80);
        addStore("sw jalr link", iInstr(OpSw, 5'd2, 5'd10, 16'h0014), 32'h84, 32'h114, 32'h58);
        addStep("bad opcode", iInstr(6'h3F, 5'd0, 5'd1, 16'hFFFF), 32'h88);
        addStep("bad funct", rInstr(5'd3, 5'd3, 5'd1, 5'd0, 6'h3F), 32'h8C);
        addStore("sw unchanged", iInstr(OpSw, 5'd2, 5'd1, 16'h0018), 32'h90, 32'h118, 32'h12345678);
        addStep("nop", 32'h0000_0000, 32'h94);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        rstN <= 1'b0;
        seed = 5572;
        randWord = $random(seed);
        cycles = 0;
        numSteps = 0;
        buildProgram();
        cycleLimit = 16 + 2 * numSteps + 20;

        for (int i = 0; i < 128; i++)
        begin
            imem[i[6:0]] = 32'h0000_0000;
        end
        curPc = ResetPc;
        for (int i = 0; i < numSteps; i++)
        begin
            imem[curPc[8:2]] = prog[i].instr;  // Placed along the trace
            curPc = prog[i].nextPc;
        end

        for (int i = 0; i < 16; i++)
        begin
            @(negedge clk);
            checkBit("reset memWe", 1'b0, memWe);
            checkBit("reset memRe", 1'b0, memRe);
            checkWord("reset pc", ResetPc, pc);
        end
        @(posedge clk);
        rstN <= 1'b1;

        curPc = ResetPc;
        for (int i = 0; i < numSteps; i++)
        begin
            @(negedge clk);
            checkWord({stepName[i], " pc"}, curPc, pc);
            checkBit({stepName[i], " memWe"}, prog[i].isStore, memWe);
            checkBit({stepName[i], " memRe"}, prog[i].isLoad, memRe);
            if (prog[i].isStore)
            begin
                checkWord({stepName[i], " memAddr"}, prog[i].addr, memAddr);
                checkWord({stepName[i], " memWdata"}, prog[i].data, memWdata);
            end
            if (prog[i].isLoad)
            begin
                checkWord({stepName[i], " memAddr"}, prog[i].addr, memAddr);
            end
            @(posedge clk);
            curPc = prog[i].nextPc;
        end
        @(negedge clk);
        checkWord("final pc", curPc, pc);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: compile.f
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/executeUnit.sv
verilog/resultStage.sv
verilog/mipsCore.sv
verification/mipsCore_assert.sv
verification/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mipsCoreTb \
    -f compile.f \
    -o mipsCoreSim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/mipsCoreSim > sim.log 2>&1
cat sim.log

grep -qxF '*** PASSED ***' sim.log && echo "Simulation run ok" || { echo "Simulation run failed"; exit 1; }
